// File: bench/rv_ref_model.svh
// Architectural register and memory model, xorshift generator and random instruction builder
`ifndef rv_ref_model_svh
`define rv_ref_model_svh

localparam int k_rtype   = 0;
localparam int k_itype   = 1;
localparam int k_upper   = 2;
localparam int k_mem     = 3;
localparam int k_unknown = 4;
localparam int k_bubble  = 5;
localparam int k_mixed   = 6;

logic [31:0] xreg [32];
int          last_wr [32];  // Acceptance cycle of the last writer
logic [7:0]  dmem [dmem_bytes];
logic [31:0] model_pc;
logic [31:0] rng_state = 32'haef7;

function automatic logic [31:0] next_rand();
    rng_state ^= rng_state << 13;
    rng_state ^= rng_state >> 17;
    rng_state ^= rng_state << 5;
    return rng_state;
endfunction

task automatic model_reset();
    for (int i = 0; i < 32; i++) begin
        xreg[i]    = '0;
        last_wr[i] = -100;
    end
    for (int i = 0; i < dmem_bytes; i++) begin
        dmem[i] = 8'h00;
    end
    model_pc = '0;
endtask

function automatic bit src_ready(logic [4:0] r, int acc);
    return r == 5'd0 || acc - last_wr[r] >= 3;
endfunction

function automatic logic [31:0] alu_ref(logic [2:0] f3, logic alt, logic [31:0] a,
                                        logic [31:0] b);
    case (f3)
        3'd0: return alt ? a - b : a + b;
        3'd1: return a << b[4:0];
        3'd2: return {31'b0, $signed(a) < $signed(b)};
        3'd3: return {31'b0, a < b};
        3'd4: return a ^ b;
        3'd5: return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
        3'd6: return a | b;
        default: return a & b;
    endcase
endfunction

// Little-endian bytes, addresses wrap at the memory size
function automatic logic [31:0] read_bytes(logic [31:0] ea, int n);
    logic [31:0] v;
    v = '0;
    for (int k = 0; k < n; k++) begin
        v[8*k +: 8] = dmem[(ea + k) % dmem_bytes];
    end
    return v;
endfunction

task automatic write_bytes(input logic [31:0] ea, input int n, input logic [31:0] v);
    for (int k = 0; k < n; k++) begin
        dmem[(ea + k) % dmem_bytes] = v[8*k +: 8];
    end
endtask

task automatic model_exec(input logic [31:0] w, input int acc, output bit wr,
                          output logic [31:0] data);
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] i_imm;
    logic [31:0] s_imm;
    logic [31:0] raw;
    int          n;
    a     = xreg[w[19:15]];
    b     = xreg[w[24:20]];
    i_imm = {{20{w[31]}}, w[31:20]};
    s_imm = {{20{w[31]}}, w[31:25], w[11:7]};
    n     = (w[13:12] == 2'd0) ? 1 : (w[13:12] == 2'd1) ? 2 : 4;
    wr    = 1'b1;
    data  = '0;
    case (w[6:0])
        opc_op:     data = alu_ref(w[14:12], w[30], a, b);
        opc_op_imm: data = alu_ref(w[14:12], w[14:12] == 3'd5 && w[30], a, i_imm);
        opc_lui:    data = {w[31:12], 12'b0};
        opc_auipc:  data = model_pc + {w[31:12], 12'b0};
        opc_load: begin
            raw  = read_bytes(a + i_imm, n);
            data = raw;
            if (!w[14] && n == 1) data = {{24{raw[7]}}, raw[7:0]};
            if (!w[14] && n == 2) data = {{16{raw[15]}}, raw[15:0]};
        end
        opc_store: begin
            write_bytes(a + s_imm, n, b);
            wr = 1'b0;
        end
        default: wr = 1'b0;  // Unknown word, only the pc moves
    endcase
    if (wr && w[11:7] != 5'd0) begin
        xreg[w[11:7]]    = data;
        last_wr[w[11:7]] = acc;
    end
    model_pc += 4;
endtask

// Builds one random word of the given kind, ok low means issue a bubble
task automatic gen_instr(input int kind, input int acc, output bit ok,
                         output logic [31:0] word);
    logic [31:0] r;
    logic [31:0] r2;
    logic [4:0]  rs1;
    logic [2:0]  f3;
    logic [11:0] imm;
    int          k;
    r   = next_rand();
    r2  = next_rand();
    rs1 = r[9:5];
    f3  = r[17:15];
    imm = r2[11:0];
    k   = kind;
    if (kind == k_mixed) begin
        k = (r[20:18] > 3'd5) ? r[20:18] - 6 : r[20:18];
    end
    ok   = 1'b1;
    word = '0;
    case (k)
        k_rtype: begin
            word = {1'b0, (f3 == 3'd0 || f3 == 3'd5) && r[21], 5'b0, r[14:10], rs1, f3,
                    r[4:0], opc_op};
            ok   = src_ready(rs1, acc) && src_ready(r[14:10], acc);
        end
        k_itype: begin
            if (f3 == 3'd1 || f3 == 3'd5) begin
                imm = {1'b0, f3 == 3'd5 && r[21], 5'b0, r2[4:0]};  // Shift amount form
            end
            word = {imm, rs1, f3, r[4:0], opc_op_imm};
            ok   = src_ready(rs1, acc);
        end
        k_upper: word = {r2[31:12], r[4:0], r[21] ? opc_lui : opc_auipc};
        k_mem: begin
            if (r[22]) rs1 = 5'd0;
            imm = 12'(r2[4:0]) - 12'd16;  // Window across the wrap point
            if (r[21]) begin
                f3   = {1'b0, (r[16:15] == 2'd3) ? 2'd2 : r[16:15]};
                word = {imm[11:5], r[14:10], rs1, f3, imm[4:0], opc_store};
                ok   = src_ready(rs1, acc) && src_ready(r[14:10], acc);
            end else begin
                if (f3 == 3'd3) f3 = 3'd2;
                else if (f3 > 3'd5) f3 = f3 - 3'd2;
                word = {imm, rs1, f3, r[4:0], opc_load};
                ok   = src_ready(rs1, acc);
            end
        end
        k_unknown: begin
            case (r[22:21])
                2'd0:    word = {r2[31:7], 7'b1100011};  // Branch
                2'd1:    word = {r2[31:7], 7'b1101111};  // JAL
                2'd2:    word = {r2[31:7], 7'b1100111};
                default: word = {r2[31:7], 7'b0001111};
            endcase
        end
        default: ok = 1'b0;
    endcase
endtask

`endif

// File: bench/rv_pipeline_tb.sv
// Testbench for rv_pipeline with random stimulus, reference model checks and watchdog
`timescale 1ns/1ps

module rv_pipeline_tb import rv_pkg::*; ();

    localparam int clk_period   = 4;
    localparam int reset_cycles = 2;
    localparam int idle_slots   = 4;
    localparam int seed_slots   = 62;
    localparam int r_slots      = 150;
    localparam int i_slots      = 150;
    localparam int u_slots      = 40;
    localparam int m_slots      = 250;
    localparam int x_slots      = 250;
    localparam int n_tests      = 6;
    localparam int drain_allow  = 16;  // Pipeline drain plus idle window
    localparam int total_slots  = reset_cycles + idle_slots + seed_slots + r_slots + i_slots
                                  + u_slots + m_slots + x_slots;
    localparam int watchdog_cycles = total_slots + n_tests * drain_allow + 10;

    logic                  clk;
    logic                  reset;
    logic [xlen-1:0]       instr;
    logic                  instr_valid;
    logic                  wb_valid;
    logic [reg_addr_w-1:0] wb_rd;
    logic [xlen-1:0]       wb_data;

    int          cycle = 0;
    int          errors = 0;
    int          checks = 0;
    int          test_errors;
    int          test_checks;
    string       test_name = "reset";
    logic [4:0]  exp_rd_q [$];
    logic [31:0] exp_data_q [$];
    int          exp_cycle_q [$];  // Acceptance edge of each writer

    `include "rv_ref_model.svh"

    rv_pipeline i_rv_pipeline (
        .clk         (clk),
        .reset       (reset),
        .instr       (instr),
        .instr_valid (instr_valid),
        .wb_valid    (wb_valid),
        .wb_rd       (wb_rd),
        .wb_data     (wb_data)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    always @(posedge clk) cycle <= cycle + 1;

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        test_checks++;
        if (actual !== expected) begin
            errors++;
            test_errors++;
            $display("Mismatch in %s %s: expected %h, actual %h", test_name, what, expected,
                     actual);
        end
    endtask

    // Writeback ports are stable at the falling edge
    always @(negedge clk) begin
        if (wb_valid === 1'b1) begin
            if (exp_rd_q.size() == 0) begin
                errors++;
                test_errors++;
                $display("Unexpected writeback to x%0d in test %s, nothing was outstanding",
                         wb_rd, test_name);
            end else begin
                check_value("rd", exp_rd_q.pop_front(), wb_rd);
                check_value("data", exp_data_q.pop_front(), wb_data);
                check_value("writeback cycle", exp_cycle_q.pop_front() + 4, cycle);
            end
        end else if (wb_valid !== 1'b0) begin
            errors++;
            test_errors++;
            $display("wb_valid is unknown in test %s", test_name);
        end
    end

    task automatic issue(input logic [31:0] word);
        bit          wr;
        logic [31:0] data;
        int          acc;
        acc         = cycle + 1;  // Edge that samples this word
        instr       = word;
        instr_valid = 1'b1;
        model_exec(word, acc, wr, data);
        if (wr) begin
            exp_rd_q.push_back(word[11:7]);
            exp_data_q.push_back(data);
            exp_cycle_q.push_back(acc);
        end
        @(posedge clk);
        #1;
    endtask

    task automatic bubble();
        instr       = next_rand();  // Junk that must be ignored
        instr_valid = 1'b0;
        @(posedge clk);
        #1;
    endtask

    task automatic start_test(input string name);
        test_name   = name;
        test_checks = 0;
        test_errors = 0;
    endtask

    task automatic end_test();
        instr_valid = 1'b0;
        while (exp_rd_q.size() != 0) begin
            @(posedge clk);
        end
        repeat (6) @(posedge clk);  // Catch stray writebacks
        #1;
        $display("Test %s done: %0d checks, %0d errors", test_name, test_checks, test_errors);
    endtask

    task automatic random_test(input string name, input int kind, input int slots);
        bit          ok;
        logic [31:0] word;
        start_test(name);
        for (int s = 0; s < slots; s++) begin
            gen_instr(kind, cycle + 1, ok, word);
            if (ok) issue(word);
            else bubble();
        end
        end_test();
    endtask

    // LUI then ADDI on every register so later tests see full values
    task automatic seed_registers();
        logic [31:0] r;
        for (int i = 1; i < 32; i++) begin
            r = next_rand();
            issue({r[31:12], 5'(i), opc_lui});
        end
        for (int i = 1; i < 32; i++) begin
            r = next_rand();
            issue({r[11:0], 5'(i), 3'b000, 5'(i), opc_op_imm});
        end
    endtask

    initial begin
        #(watchdog_cycles * clk_period);
        $display("Watchdog expired in test %s with %0d writebacks still outstanding",
                 test_name, exp_rd_q.size());
        $display("ERRORS FOUND");
        $finish;
    end

    initial begin
        reset       = 1'b1;
        instr       = '0;
        instr_valid = 1'b0;
        model_reset();
        start_test("reset");
        repeat (reset_cycles) @(posedge clk);
        #1;
        reset = 1'b0;
        repeat (idle_slots) bubble();  // No writeback expected yet
        seed_registers();
        end_test();

        random_test("r_type", k_rtype, r_slots);
        random_test("i_type", k_itype, i_slots);
        random_test("lui_auipc", k_upper, u_slots);
        random_test("load_store", k_mem, m_slots);
        random_test("bubbles_and_order", k_mixed, x_slots);

        $display("Total: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// File: build.f
+incdir+bench
rtl/rv_pkg.sv
rtl/inst_decoder.sv
rtl/reg_file.sv
rtl/execute_unit.sv
rtl/data_memory.sv
rtl/rv_pipeline.sv
bench/rv_pipeline_tb.sv

// File: rtl/data_memory.sv
// Byte-addressed data memory with sized stores and extended loads
`timescale 1ns/1ps

module data_memory import rv_pkg::*; (
    input  logic                   clk,
    input  logic                   reset,
    input  logic [dmem_addr_w-1:0] addr,
    input  logic                   write_en,
    input  access_size_t           size,
    input  logic                   sign_ext,
    input  logic [xlen-1:0]        write_data,
    output logic [xlen-1:0]        read_data
);

    logic [7:0] mem [dmem_bytes];

    // Neighbouring byte addresses wrap around the array
    logic [dmem_addr_w-1:0] addr1;
    logic [dmem_addr_w-1:0] addr2;
    logic [dmem_addr_w-1:0] addr3;

    assign addr1 = addr + dmem_addr_w'(1);
    assign addr2 = addr + dmem_addr_w'(2);
    assign addr3 = addr + dmem_addr_w'(3);

    // Little-endian store of the low 1, 2 or 4 bytes
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < dmem_bytes; i++) begin
                mem[i] <= 8'h00;
            end
        end else if (write_en) begin
            mem[addr] <= write_data[7:0];
            if (size != byte_acc) begin
                mem[addr1] <= write_data[15:8];
            end
            if (size == word_acc) begin
                mem[addr2] <= write_data[23:16];
                mem[addr3] <= write_data[31:24];
            end
        end
    end

    always_comb begin
        case (size)
            byte_acc: read_data = {{24{sign_ext & mem[addr][7]}}, mem[addr]};
            half_acc: begin
                read_data = {{16{sign_ext & mem[addr1][7]}}, mem[addr1], mem[addr]};
            end
            default:  read_data = {mem[addr3], mem[addr2], mem[addr1], mem[addr]};
        endcase
    end

endmodule

// File: rtl/execute_unit.sv
// Execute stage: first-operand select, second-operand handler and ALU
`timescale 1ns/1ps

module execute_unit import rv_pkg::*; (
    input  logic [xlen-1:0] operand_a_reg,
    input  logic [xlen-1:0] operand_b_reg,
    input  logic [xlen-1:0] pc,
    input  logic [xlen-1:0] imm,
    input  logic            use_pc,
    input  operand_sel_t    operand_sel,
    input  alu_op_t         alu_op,
    output logic [xlen-1:0] result
);

    logic [xlen-1:0] op_a;
    logic [xlen-1:0] op_b;
    logic [4:0]      shamt;

    // AUIPC takes the pc as first operand
    assign op_a = use_pc ? pc : operand_a_reg;

    // Any immediate format arrives already extended
    always_comb begin
        case (operand_sel)
            reg_b:   op_b = operand_b_reg;
            imm_i,
            imm_s,
            imm_u:   op_b = imm;
            default: op_b = '0;
        endcase
    end

    assign shamt = op_b[4:0];

    always_comb begin
        case (alu_op)
            pass_b: result = op_b;
            add:    result = op_a + op_b;
            sub:    result = op_a - op_b;
            sll:    result = op_a << shamt;
            srl:    result = op_a >> shamt;
            sra:    result = $signed(op_a) >>> shamt; // Sign bit refills
            slt: begin
                result = {31'b0, $signed(op_a) < $signed(op_b)};
            end
            sltu: begin
                result = {31'b0, op_a < op_b};
            end
            and_op: result = op_a & op_b;
            or_op:  result = op_a | op_b;
            xor_op: result = op_a ^ op_b;
            default: result = '0;
        endcase
    end

endmodule

// File: rtl/inst_decoder.sv
// Instruction decoder producing control fields and the sign-extended immediate
`timescale 1ns/1ps

module inst_decoder import rv_pkg::*; (
    input  logic [xlen-1:0]       instr,
    output logic                  valid_op,
    output logic [reg_addr_w-1:0] rd,
    output logic [reg_addr_w-1:0] rs1,
    output logic [reg_addr_w-1:0] rs2,
    output alu_op_t               alu_op,
    output operand_sel_t          operand_sel,
    output logic                  use_pc,
    output logic                  rf_write,
    output logic                  mem_read,
    output logic                  mem_write,
    output access_size_t          size,
    output logic                  sign_ext,
    output logic [xlen-1:0]       imm
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       alt;  // Bit 30 picks SUB and SRA/SRAI

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign alt    = instr[30];

    assign rd  = instr[11:7];
    assign rs1 = instr[19:15];
    assign rs2 = instr[24:20];

    always_comb begin
        valid_op    = 1'b1;
        alu_op      = add;
        operand_sel = reg_b;
        use_pc      = 1'b0;
        rf_write    = 1'b0;
        mem_read    = 1'b0;
        mem_write   = 1'b0;
        size        = word_acc;
        sign_ext    = 1'b0;

        case (opcode)
            opc_op, opc_op_imm: begin
                rf_write    = 1'b1;
                operand_sel = (opcode == opc_op) ? reg_b : imm_i;
                case (funct3)
                    3'b000: alu_op = (opcode == opc_op && alt) ? sub : add; // No SUBI
                    3'b001: alu_op = sll;
                    3'b010: alu_op = slt;
                    3'b011: alu_op = sltu;
                    3'b100: alu_op = xor_op;
                    3'b101: alu_op = alt ? sra : srl;
                    3'b110: alu_op = or_op;
                    default: alu_op = and_op;
                endcase
            end
            opc_load: begin
                operand_sel = imm_i;
                rf_write    = 1'b1;
                mem_read    = 1'b1;
                case (funct3)
                    3'b000: begin // LB
                        size     = byte_acc;
                        sign_ext = 1'b1;
                    end
                    3'b001: begin // LH
                        size     = half_acc;
                        sign_ext = 1'b1;
                    end
                    3'b010: size = word_acc;
                    3'b100: size = byte_acc;                      // LBU
                    3'b101: size = half_acc;                      // LHU
                    default: valid_op = 1'b0;
                endcase
            end
            opc_store: begin
                operand_sel = imm_s;
                mem_write   = 1'b1;
                case (funct3)
                    3'b000: size = byte_acc;
                    3'b001: size = half_acc;
                    3'b010: size = word_acc;
                    default: valid_op = 1'b0;
                endcase
            end
            opc_lui: begin
                alu_op      = pass_b;
                operand_sel = imm_u;
                rf_write    = 1'b1;
            end
            opc_auipc: begin
                operand_sel = imm_u;
                use_pc      = 1'b1;  // pc + upper immediate
                rf_write    = 1'b1;
            end
            default: valid_op = 1'b0; // Treated as a bubble
        endcase
    end

    // Immediate format follows the operand select
    always_comb begin
        case (operand_sel)
            imm_i:   imm = {{20{instr[31]}}, instr[31:20]};
            imm_s:   imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            imm_u:   imm = {instr[31:12], 12'b0};
            default: imm = '0;
        endcase
    end

endmodule

// File: rtl/reg_file.sv
// Register file, 32 x 32 bits, x0 hardwired to zero, write-through reads
`timescale 1ns/1ps

module reg_file import rv_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    input  logic [reg_addr_w-1:0] rs1,
    input  logic [reg_addr_w-1:0] rs2,
    input  logic                  we,
    input  logic [reg_addr_w-1:0] wd_addr,
    input  logic [xlen-1:0]       wd_data,
    output logic [xlen-1:0]       rd1,
    output logic [xlen-1:0]       rd2
);

    logic [xlen-1:0] regs [32];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && wd_addr != '0) begin // x0 never written
            regs[wd_addr] <= wd_data;
        end
    end

    // Same-cycle write is visible to the reader
    assign rd1 = (rs1 == '0) ? '0 :
                 (we && wd_addr == rs1) ? wd_data : regs[rs1];
    assign rd2 = (rs2 == '0) ? '0 :
                 (we && wd_addr == rs2) ? wd_data : regs[rs2];

endmodule

// File: rtl/rv_pipeline.sv
// Five-stage RV32I datapath top level: pc, stage registers and stage blocks
`timescale 1ns/1ps

module rv_pipeline import rv_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    input  logic [xlen-1:0]       instr,
    input  logic                  instr_valid,
    output logic                  wb_valid,
    output logic [reg_addr_w-1:0] wb_rd,
    output logic [xlen-1:0]       wb_data
);

    logic [xlen-1:0] pc;
    logic [xlen-1:0] pc_plus4;

    logic            id_valid;
    logic [xlen-1:0] id_instr;
    logic [xlen-1:0] id_pc;

    // Decoder outputs
    logic                  dec_valid_op;
    logic [reg_addr_w-1:0] dec_rd;
    logic [reg_addr_w-1:0] dec_rs1;
    logic [reg_addr_w-1:0] dec_rs2;
    alu_op_t               dec_alu_op;
    operand_sel_t          dec_operand_sel;
    logic                  dec_use_pc;
    logic                  dec_rf_write;
    logic                  dec_mem_read;
    logic                  dec_mem_write;
    access_size_t          dec_size;
    logic                  dec_sign_ext;
    logic [xlen-1:0]       dec_imm;
    logic [xlen-1:0]       rs1_data;
    logic [xlen-1:0]       rs2_data;

    logic                  ex_valid;
    logic [reg_addr_w-1:0] ex_rd;
    alu_op_t               ex_alu_op;
    operand_sel_t          ex_operand_sel;
    logic                  ex_use_pc;
    logic                  ex_rf_write;
    logic                  ex_mem_read;
    logic                  ex_mem_write;
    access_size_t          ex_size;
    logic                  ex_sign_ext;
    logic [xlen-1:0]       ex_imm;
    logic [xlen-1:0]       ex_pc;
    logic [xlen-1:0]       ex_rs1_data;
    logic [xlen-1:0]       ex_rs2_data;
    logic [xlen-1:0]       alu_result;

    logic                  mem_valid;
    logic [reg_addr_w-1:0] mem_rd;
    logic                  mem_rf_write;
    logic                  mem_mem_read;
    logic                  mem_mem_write;
    access_size_t          mem_size;
    logic                  mem_sign_ext;
    logic [xlen-1:0]       mem_result;
    logic [xlen-1:0]       mem_store_data;
    logic [xlen-1:0]       load_data;

    // Writeback stage register, feeds the register file write
    logic                  wr_valid;
    logic [reg_addr_w-1:0] wr_rd;
    logic [xlen-1:0]       wr_data;

    assign pc_plus4 = pc + 32'd4;

    // Stage valid bits and pc, a missing instruction becomes a bubble
    always_ff @(posedge clk) begin
        if (reset) begin
            pc        <= '0;
            id_valid  <= 1'b0;
            ex_valid  <= 1'b0;
            mem_valid <= 1'b0;
            wr_valid  <= 1'b0;
            wb_valid  <= 1'b0;
        end else begin
            if (instr_valid) begin
                pc <= pc_plus4;
            end
            id_valid  <= instr_valid;
            ex_valid  <= id_valid & dec_valid_op;  // Unknown opcode dropped
            mem_valid <= ex_valid;
            wr_valid  <= mem_valid & mem_rf_write; // Only rd writers retire
            wb_valid  <= wr_valid;
        end
    end

    // Payload follows the instruction down the pipe
    always_ff @(posedge clk) begin
        if (instr_valid) begin
            id_instr <= instr;
            id_pc    <= pc;
        end

        ex_rd          <= dec_rd;
        ex_alu_op      <= dec_alu_op;
        ex_operand_sel <= dec_operand_sel;
        ex_use_pc      <= dec_use_pc;
        ex_rf_write    <= dec_rf_write;
        ex_mem_read    <= dec_mem_read;
        ex_mem_write   <= dec_mem_write;
        ex_size        <= dec_size;
        ex_sign_ext    <= dec_sign_ext;
        ex_imm         <= dec_imm;
        ex_pc          <= id_pc;
        ex_rs1_data    <= rs1_data;
        ex_rs2_data    <= rs2_data;

        mem_rd         <= ex_rd;
        mem_rf_write   <= ex_rf_write;
        mem_mem_read   <= ex_mem_read;
        mem_mem_write  <= ex_mem_write;
        mem_size       <= ex_size;
        mem_sign_ext   <= ex_sign_ext;
        mem_result     <= alu_result;
        mem_store_data <= ex_rs2_data;

        wr_rd   <= mem_rd;
        wr_data <= mem_mem_read ? load_data : mem_result;

        wb_rd   <= wr_rd;   // Same edge as the register file write
        wb_data <= wr_data;
    end

    inst_decoder i_inst_decoder (
        .instr       (id_instr),
        .valid_op    (dec_valid_op),
        .rd          (dec_rd),
        .rs1         (dec_rs1),
        .rs2         (dec_rs2),
        .alu_op      (dec_alu_op),
        .operand_sel (dec_operand_sel),
        .use_pc      (dec_use_pc),
        .rf_write    (dec_rf_write),
        .mem_read    (dec_mem_read),
        .mem_write   (dec_mem_write),
        .size        (dec_size),
        .sign_ext    (dec_sign_ext),
        .imm         (dec_imm)
    );

    reg_file i_reg_file (
        .clk     (clk),
        .reset   (reset),
        .rs1     (dec_rs1),
        .rs2     (dec_rs2),
        .we      (wr_valid),
        .wd_addr (wr_rd),
        .wd_data (wr_data),
        .rd1     (rs1_data),
        .rd2     (rs2_data)
    );

    execute_unit i_execute_unit (
        .operand_a_reg (ex_rs1_data),
        .operand_b_reg (ex_rs2_data),
        .pc            (ex_pc),
        .imm           (ex_imm),
        .use_pc        (ex_use_pc),
        .operand_sel   (ex_operand_sel),
        .alu_op        (ex_alu_op),
        .result        (alu_result)
    );

    // Address is the low bits of the effective address
    data_memory i_data_memory (
        .clk        (clk),
        .reset      (reset),
        .addr       (mem_result[dmem_addr_w-1:0]),
        .write_en   (mem_valid & mem_mem_write),
        .size       (mem_size),
        .sign_ext   (mem_sign_ext),
        .write_data (mem_store_data),
        .read_data  (load_data)
    );

endmodule

// File: rtl/rv_pkg.sv
// Widths, major opcodes, ALU operations, operand selects and access sizes
package rv_pkg;

    localparam int xlen        = 32;  // Data and address width
    localparam int reg_addr_w  = 5;
    localparam int dmem_bytes  = 512;
    localparam int dmem_addr_w = 9;   // Byte address into data memory

    // Major opcodes of the supported subset
    localparam logic [6:0] opc_op     = 7'b0110011; // R-type ALU
    localparam logic [6:0] opc_op_imm = 7'b0010011; // I-type ALU
    localparam logic [6:0] opc_load   = 7'b0000011;
    localparam logic [6:0] opc_store  = 7'b0100011;
    localparam logic [6:0] opc_lui    = 7'b0110111;
    localparam logic [6:0] opc_auipc  = 7'b0010111;

    // ALU operation codes
    typedef enum logic [3:0] {
        pass_b = 4'b0000,  // Second operand straight through
        add    = 4'b0010,
        sub    = 4'b0011,
        sll    = 4'b0101,
        srl    = 4'b0110,
        sra    = 4'b0111,
        slt    = 4'b1000,  // Signed compare
        sltu   = 4'b1001,
        and_op = 4'b1010,
        or_op  = 4'b1011,
        xor_op = 4'b1100
    } alu_op_t;

    // Second operand source and immediate format
    typedef enum logic [2:0] {
        reg_b = 3'b000,
        imm_i = 3'b001,
        imm_s = 3'b010,
        imm_u = 3'b011
    } operand_sel_t;

    typedef enum logic [1:0] {
        byte_acc = 2'b00,
        half_acc = 2'b01,
        word_acc = 2'b10
    } access_size_t;

endpackage
